/* design/periph_settings.svh */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Address map, slot field in paddr[15:12]
`define PERIPH_SLOT_LSB        12
`define PERIPH_SLOT_MSB        15
`define PERIPH_SLOT_GPIO       0
`define PERIPH_SLOT_TIMER      1
`define PERIPH_SLOT_EVENT      2
`define PERIPH_SLOT_SOC        3

// Word register indices per slot
`define PERIPH_GPIO_DIR        2'd0
`define PERIPH_GPIO_OUT        2'd1
`define PERIPH_GPIO_IN         2'd2
`define PERIPH_GPIO_INT_EN     2'd3
`define PERIPH_TIMER_CTRL      2'd0
`define PERIPH_TIMER_COUNT     2'd1
`define PERIPH_TIMER_CMP       2'd2
`define PERIPH_EVT_IRQ_EN      2'd0
`define PERIPH_EVT_PENDING     2'd1
`define PERIPH_EVT_SET         2'd2
`define PERIPH_SOC_BOOT_ADDR   2'd0
`define PERIPH_SOC_PAD_MUX     2'd1
`define PERIPH_SOC_CLK_GATE    2'd2
`define PERIPH_SOC_INFO        2'd3

// Reset values
`define PERIPH_ROM_START_ADDR  32'h0000_8000
`define PERIPH_CLK_GATE_RST    4'hF          // All slots enabled
`define PERIPH_TIMER_CMP_RST   32'hFFFF_FFFF
`define PERIPH_SOC_INFO_VALUE  32'd4         // Number of slots

// Event vector positions
`define PERIPH_EVT_GPIO_BIT    25
`define PERIPH_EVT_TIMER_BIT   28

`endif

/* design/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  typedef logic [31:0] apb_addr_t;   // APB byte address
  typedef logic [31:0] apb_data_t;   // APB read and write data

  // One bit per peripheral slot
  typedef logic [3:0]  slot_sel_t;

  typedef logic [1:0]  reg_idx_t;    // Word index, paddr[3:2]

  // Interrupt and event vector toward the core
  typedef logic [31:0] irq_vec_t;

endpackage

`default_nettype wire

/* design/periph_apb_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_apb_decode (
  input  periph_pkg::apb_addr_t paddr_i,
  output periph_pkg::slot_sel_t sel_o
);

  // Slot field of the address
  logic [`PERIPH_SLOT_MSB-`PERIPH_SLOT_LSB:0] slot;

  assign slot = paddr_i[`PERIPH_SLOT_MSB:`PERIPH_SLOT_LSB];

  //////////////////////////////////////////////////////////////////////
  // One-hot select, slots 4..15 leave every bit low
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_o                     = '0;
    sel_o[`PERIPH_SLOT_GPIO]  = (slot == `PERIPH_SLOT_GPIO);
    sel_o[`PERIPH_SLOT_TIMER] = (slot == `PERIPH_SLOT_TIMER);
    sel_o[`PERIPH_SLOT_EVENT] = (slot == `PERIPH_SLOT_EVENT);
    sel_o[`PERIPH_SLOT_SOC]   = (slot == `PERIPH_SLOT_SOC);
  end

endmodule

`default_nettype wire

/* design/periph_gpio.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_gpio (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  sel_i,      // Slot select from decoder
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::reg_idx_t  idx_i,
  input  periph_pkg::apb_data_t wdata_i,
  input  logic                  gate_i,     // Input sampling enable
  input  periph_pkg::apb_data_t gpio_in_i,
  output periph_pkg::apb_data_t rdata_o,
  output periph_pkg::apb_data_t gpio_out_o,
  output periph_pkg::apb_data_t gpio_dir_o,
  output logic                  evt_o
);

  periph_pkg::apb_data_t dir_q;
  periph_pkg::apb_data_t out_q;
  periph_pkg::apb_data_t int_en_q;
  periph_pkg::apb_data_t sync_q;     // First synchronizer stage
  periph_pkg::apb_data_t in_q;       // IN register, second stage
  periph_pkg::apb_data_t in_prev_q;  // IN one cycle ago
  logic                  evt_q;
  logic                  wr_en;

  assign wr_en = sel_i & psel_i & penable_i & pwrite_i;  // Access phase write

  // Config registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
    end else if (wr_en) begin
      case (idx_i)
        `PERIPH_GPIO_DIR:    dir_q    <= wdata_i;
        `PERIPH_GPIO_OUT:    out_q    <= wdata_i;
        `PERIPH_GPIO_INT_EN: int_en_q <= wdata_i;
        default: ;                                      // IN is read-only
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer and change detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q    <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
      evt_q     <= 1'b0;
    end else begin
      if (gate_i) begin                                 // Frozen while gated off
        sync_q <= gpio_in_i;
        in_q   <= sync_q;
      end
      in_prev_q <= in_q;
      evt_q     <= |((in_q ^ in_prev_q) & int_en_q);    // Enabled bits only
    end
  end

  assign evt_o      = evt_q;
  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;

  // Read data
  always_comb begin
    case (idx_i)
      `PERIPH_GPIO_DIR: rdata_o = dir_q;
      `PERIPH_GPIO_OUT: rdata_o = out_q;
      `PERIPH_GPIO_IN:  rdata_o = in_q;
      default:          rdata_o = int_en_q;
    endcase
  end

endmodule

`default_nettype wire

/* design/periph_timer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_timer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  sel_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::reg_idx_t  idx_i,
  input  periph_pkg::apb_data_t wdata_i,
  input  logic                  gate_i,    // Count enable from SoC control
  output periph_pkg::apb_data_t rdata_o,
  output logic                  evt_o
);

  logic                  en_q;      // CTRL bit 0
  periph_pkg::apb_data_t count_q;
  periph_pkg::apb_data_t cmp_q;
  logic                  wr_en;
  logic                  run;
  logic                  match;

  assign wr_en = sel_i & psel_i & penable_i & pwrite_i;
  assign run   = en_q & gate_i;
  assign match = (count_q == cmp_q);

  // Compare hit, one cycle since the count wraps on the next edge
  assign evt_o = run & match;

  //////////////////////////////////////////////////////////////////////
  // Control and compare registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q  <= 1'b0;
      cmp_q <= `PERIPH_TIMER_CMP_RST;
    end else if (wr_en) begin
      case (idx_i)
        `PERIPH_TIMER_CTRL: en_q  <= wdata_i[0];
        `PERIPH_TIMER_CMP:  cmp_q <= wdata_i;
        default: ;                               // COUNT handled below
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (wr_en && (idx_i == `PERIPH_TIMER_COUNT)) begin
      count_q <= wdata_i;                        // Bus write wins over counting
    end else if (run) begin
      if (match) begin
        count_q <= '0;                           // Wrap on compare
      end else begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // Read data
  always_comb begin
    case (idx_i)
      `PERIPH_TIMER_CTRL:  rdata_o = {31'd0, en_q};
      `PERIPH_TIMER_COUNT: rdata_o = count_q;
      `PERIPH_TIMER_CMP:   rdata_o = cmp_q;
      default:             rdata_o = '0;         // Unused word
    endcase
  end

endmodule

`default_nettype wire

/* design/periph_event_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_event_unit (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  sel_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::reg_idx_t  idx_i,
  input  periph_pkg::apb_data_t wdata_i,
  input  logic                  gpio_evt_i,   // One-cycle pulses
  input  logic                  timer_evt_i,
  output periph_pkg::apb_data_t rdata_o,
  output periph_pkg::irq_vec_t  irq_o
);

  periph_pkg::irq_vec_t irq_en_q;
  periph_pkg::irq_vec_t pending_q;
  periph_pkg::irq_vec_t evt_vec;    // Events at their vector positions
  periph_pkg::irq_vec_t clr_vec;
  periph_pkg::irq_vec_t set_vec;
  logic                 wr_en;

  assign wr_en = sel_i & psel_i & penable_i & pwrite_i;

  //////////////////////////////////////////////////////////////////////
  // Event mapping and software set / clear
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    evt_vec                        = '0;
    evt_vec[`PERIPH_EVT_GPIO_BIT]  = gpio_evt_i;
    evt_vec[`PERIPH_EVT_TIMER_BIT] = timer_evt_i;
  end

  assign clr_vec = (wr_en && (idx_i == `PERIPH_EVT_PENDING)) ? wdata_i : '0;  // W1C
  assign set_vec = (wr_en && (idx_i == `PERIPH_EVT_SET))     ? wdata_i : '0;  // W1S

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_en_q  <= '0;
      pending_q <= '0;
    end else begin
      if (wr_en && (idx_i == `PERIPH_EVT_IRQ_EN)) begin
        irq_en_q <= wdata_i;
      end
      // Set terms applied after the clear, so an event beats a clear
      pending_q <= (pending_q & ~clr_vec) | set_vec | evt_vec;
    end
  end

  assign irq_o = pending_q & irq_en_q;   // Masked vector

  // Read data, SET and word 3 read back 0
  always_comb begin
    case (idx_i)
      `PERIPH_EVT_IRQ_EN:  rdata_o = irq_en_q;
      `PERIPH_EVT_PENDING: rdata_o = pending_q;
      default:             rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/periph_soc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_soc_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  sel_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::reg_idx_t  idx_i,
  input  periph_pkg::apb_data_t wdata_i,
  output periph_pkg::apb_data_t rdata_o,
  output periph_pkg::apb_data_t boot_addr_o,
  output periph_pkg::apb_data_t pad_mux_o,
  output periph_pkg::slot_sel_t clk_gate_o   // Per-slot enables
);

  periph_pkg::apb_data_t boot_addr_q;
  periph_pkg::apb_data_t pad_mux_q;
  periph_pkg::slot_sel_t clk_gate_q;
  logic                  wr_en;

  assign wr_en = sel_i & psel_i & penable_i & pwrite_i;

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= `PERIPH_ROM_START_ADDR;  // Boot from ROM
      pad_mux_q   <= '0;
      clk_gate_q  <= `PERIPH_CLK_GATE_RST;
    end else if (wr_en) begin
      case (idx_i)
        `PERIPH_SOC_BOOT_ADDR: boot_addr_q <= wdata_i;
        `PERIPH_SOC_PAD_MUX:   pad_mux_q   <= wdata_i;
        `PERIPH_SOC_CLK_GATE:  clk_gate_q  <= wdata_i[3:0];  // Low nibble only
        default: ;                                           // INFO is read-only
      endcase
    end
  end

  assign boot_addr_o = boot_addr_q;
  assign pad_mux_o   = pad_mux_q;
  assign clk_gate_o  = clk_gate_q;

  // Read data
  always_comb begin
    case (idx_i)
      `PERIPH_SOC_BOOT_ADDR: rdata_o = boot_addr_q;
      `PERIPH_SOC_PAD_MUX:   rdata_o = pad_mux_q;
      `PERIPH_SOC_CLK_GATE:  rdata_o = {28'd0, clk_gate_q};
      default:               rdata_o = `PERIPH_SOC_INFO_VALUE;
    endcase
  end

endmodule

`default_nettype wire

/* design/periph_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_read_mux (
  input  periph_pkg::slot_sel_t sel_i,
  input  periph_pkg::apb_data_t gpio_rdata_i,
  input  periph_pkg::apb_data_t timer_rdata_i,
  input  periph_pkg::apb_data_t event_rdata_i,
  input  periph_pkg::apb_data_t soc_rdata_i,
  input  logic                  penable_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  // One-hot pick, zero when no slot matches
  always_comb begin
    prdata_o = '0;
    case (1'b1)
      sel_i[`PERIPH_SLOT_GPIO]:  prdata_o = gpio_rdata_i;
      sel_i[`PERIPH_SLOT_TIMER]: prdata_o = timer_rdata_i;
      sel_i[`PERIPH_SLOT_EVENT]: prdata_o = event_rdata_i;
      sel_i[`PERIPH_SLOT_SOC]:   prdata_o = soc_rdata_i;
      default: ;
    endcase
  end

  assign pready_o  = penable_i;               // Zero wait states
  assign pslverr_o = penable_i & ~(|sel_i);   // Unmapped slot

endmodule

`default_nettype wire

/* design/periph_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_subsystem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // APB slave port
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::apb_addr_t paddr_i,
  input  periph_pkg::apb_data_t pwdata_i,
  output periph_pkg::apb_data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // Pads and core side
  input  periph_pkg::apb_data_t gpio_in_i,
  output periph_pkg::apb_data_t gpio_out_o,
  output periph_pkg::apb_data_t gpio_dir_o,
  output periph_pkg::irq_vec_t  irq_o,
  output periph_pkg::apb_data_t boot_addr_o,
  output periph_pkg::apb_data_t pad_mux_o
);

  periph_pkg::slot_sel_t sel;
  periph_pkg::reg_idx_t  idx;
  periph_pkg::apb_data_t gpio_rdata;
  periph_pkg::apb_data_t timer_rdata;
  periph_pkg::apb_data_t event_rdata;
  periph_pkg::apb_data_t soc_rdata;
  periph_pkg::slot_sel_t clk_gate;
  logic                  gpio_evt;
  logic                  timer_evt;

  assign idx = paddr_i[3:2];   // Word index inside a slot

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  periph_apb_decode i_decode (
    .paddr_i ( paddr_i ),
    .sel_o   ( sel     )
  );

  //////////////////////////////////////////////////////////////////////
  // Peripheral slaves
  //////////////////////////////////////////////////////////////////////

  periph_gpio i_gpio (
    .clk_i      ( clk_i                       ),
    .rst_n_i    ( rst_n_i                     ),
    .sel_i      ( sel[`PERIPH_SLOT_GPIO]      ),
    .psel_i     ( psel_i                      ),
    .penable_i  ( penable_i                   ),
    .pwrite_i   ( pwrite_i                    ),
    .idx_i      ( idx                         ),
    .wdata_i    ( pwdata_i                    ),
    .gate_i     ( clk_gate[`PERIPH_SLOT_GPIO] ),
    .gpio_in_i  ( gpio_in_i                   ),
    .rdata_o    ( gpio_rdata                  ),
    .gpio_out_o ( gpio_out_o                  ),
    .gpio_dir_o ( gpio_dir_o                  ),
    .evt_o      ( gpio_evt                    )
  );

  periph_timer i_timer (
    .clk_i     ( clk_i                        ),
    .rst_n_i   ( rst_n_i                      ),
    .sel_i     ( sel[`PERIPH_SLOT_TIMER]      ),
    .psel_i    ( psel_i                       ),
    .penable_i ( penable_i                    ),
    .pwrite_i  ( pwrite_i                     ),
    .idx_i     ( idx                          ),
    .wdata_i   ( pwdata_i                     ),
    .gate_i    ( clk_gate[`PERIPH_SLOT_TIMER] ),
    .rdata_o   ( timer_rdata                  ),
    .evt_o     ( timer_evt                    )
  );

  periph_event_unit i_event_unit (
    .clk_i       ( clk_i                   ),
    .rst_n_i     ( rst_n_i                 ),
    .sel_i       ( sel[`PERIPH_SLOT_EVENT] ),
    .psel_i      ( psel_i                  ),
    .penable_i   ( penable_i               ),
    .pwrite_i    ( pwrite_i                ),
    .idx_i       ( idx                     ),
    .wdata_i     ( pwdata_i                ),
    .gpio_evt_i  ( gpio_evt                ),
    .timer_evt_i ( timer_evt               ),
    .rdata_o     ( event_rdata             ),
    .irq_o       ( irq_o                   )
  );

  periph_soc_ctrl i_soc_ctrl (
    .clk_i       ( clk_i                 ),
    .rst_n_i     ( rst_n_i               ),
    .sel_i       ( sel[`PERIPH_SLOT_SOC] ),
    .psel_i      ( psel_i                ),
    .penable_i   ( penable_i             ),
    .pwrite_i    ( pwrite_i              ),
    .idx_i       ( idx                   ),
    .wdata_i     ( pwdata_i              ),
    .rdata_o     ( soc_rdata             ),
    .boot_addr_o ( boot_addr_o           ),
    .pad_mux_o   ( pad_mux_o             ),
    .clk_gate_o  ( clk_gate              )
  );

  //////////////////////////////////////////////////////////////////////
  // Read result
  //////////////////////////////////////////////////////////////////////

  periph_read_mux i_read_mux (
    .sel_i         ( sel         ),
    .gpio_rdata_i  ( gpio_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .event_rdata_i ( event_rdata ),
    .soc_rdata_i   ( soc_rdata   ),
    .penable_i     ( penable_i   ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   )
  );

endmodule

`default_nettype wire

/* dv/tb_periph_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module tb_periph_subsystem;

  localparam int RESET_CYCLES    = 8;
  localparam int XFER_CYCLES     = 3;     // Setup, access and idle
  localparam int NUM_XFERS       = 100;   // Upper bound over all tests
  localparam int WAIT_CYCLES     = 80;    // Idle waits and IRQ polls
  localparam int MARGIN_CYCLES   = 2000;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_XFERS * XFER_CYCLES
                                   + WAIT_CYCLES + MARGIN_CYCLES;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  periph_pkg::apb_addr_t paddr;
  periph_pkg::apb_data_t pwdata;
  periph_pkg::apb_data_t prdata;
  logic                  pready;
  logic                  pslverr;
  periph_pkg::apb_data_t gpio_in;
  periph_pkg::apb_data_t gpio_out;
  periph_pkg::apb_data_t gpio_dir;
  periph_pkg::irq_vec_t  irq;
  periph_pkg::apb_data_t boot_addr;
  periph_pkg::apb_data_t pad_mux;
  integer                seed;
  int                    err_cnt  = 0;   // Failed checks
  int                    pass_cnt = 0;   // Tests passed
  int                    fail_cnt = 0;

  // Expected register contents from the writes issued so far
  periph_pkg::apb_data_t boot_exp;
  periph_pkg::apb_data_t pad_exp;
  periph_pkg::apb_data_t dir_exp;

  always #4 clk = ~clk;                  // 8 ns period

  periph_subsystem i_dut (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .psel_i      ( psel      ),
    .penable_i   ( penable   ),
    .pwrite_i    ( pwrite    ),
    .paddr_i     ( paddr     ),
    .pwdata_i    ( pwdata    ),
    .prdata_o    ( prdata    ),
    .pready_o    ( pready    ),
    .pslverr_o   ( pslverr   ),
    .gpio_in_i   ( gpio_in   ),
    .gpio_out_o  ( gpio_out  ),
    .gpio_dir_o  ( gpio_dir  ),
    .irq_o       ( irq       ),
    .boot_addr_o ( boot_addr ),
    .pad_mux_o   ( pad_mux   )
  );

  //////////////////////////////////////////////////////////////////////
  // Bus protocol checks in every access cycle
  //////////////////////////////////////////////////////////////////////

  a_pready: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> pready)
    else begin
      $display("CHECK FAILED @%0t: pready_o low in an access cycle", $time);
      err_cnt++;
    end

  // Mapped slots 0..3 never flag an error
  a_mapped: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && (paddr[15:12] < 4'd4)) |-> !pslverr)
    else begin
      $display("CHECK FAILED @%0t: pslverr_o high for address %h", $time, paddr);
      err_cnt++;
    end

  a_unmapped: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && (paddr[15:12] >= 4'd4)) |-> (pslverr && (prdata == '0)))
    else begin
      $display("CHECK FAILED @%0t: bad error response for address %h", $time, paddr);
      err_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Slot in paddr[15:12] and word index in paddr[3:2]
  function automatic periph_pkg::apb_addr_t reg_addr(input int slot, input int idx);
    reg_addr = (slot << 12) | (idx << 2);
  endfunction

  task automatic expect_equal(input periph_pkg::apb_data_t actual,
                              input periph_pkg::apb_data_t expected, input string what);
    assert (actual === expected) else begin
      $display("CHECK FAILED @%0t: %s is %h, expected %h", $time, what, actual, expected);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("CHECK FAILED @%0t: %s does not hold", $time, what);
      err_cnt++;
    end
  endtask

  // One APB transfer that returns at the edge ending the access cycle
  task automatic apb_transfer(input logic write, input periph_pkg::apb_addr_t addr,
                              input periph_pkg::apb_data_t wdata,
                              output periph_pkg::apb_data_t rdata, output logic slverr);
    int waits;
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;                     // Setup cycle
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;                     // Access cycle
    @(negedge clk);
    while (!pready && waits < 16) begin  // Bounded wait for pready
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      $display("APB transfer to %h got no pready after %0d cycles", addr, waits);
      err_cnt++;
    end
    rdata  = prdata;                     // Sampled mid-cycle
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input periph_pkg::apb_addr_t addr, input periph_pkg::apb_data_t data);
    periph_pkg::apb_data_t unused_rd;
    logic                  unused_err;
    apb_transfer(1'b1, addr, data, unused_rd, unused_err);
  endtask

  task automatic apb_read(input periph_pkg::apb_addr_t addr, output periph_pkg::apb_data_t data);
    logic unused_err;
    apb_transfer(1'b0, addr, '0, data, unused_err);
  endtask

  // Poll irq_o at falling edges
  task automatic wait_irq_bit(input int pos, input int max_cycles);
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < max_cycles && !seen; n++) begin
      @(negedge clk);
      seen = irq[pos];
    end
    assert (seen) else begin
      $display("irq_o bit %0d did not rise within %0d cycles", pos, max_cycles);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start) begin
      pass_cnt++;
      $display("[%0t] %s: passed", $time, name);
    end else begin
      fail_cnt++;
      $display("[%0t] %s: failed with %0d errors", $time, name, err_cnt - errs_at_start);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    periph_pkg::apb_data_t rd;
    int                    errs;
    errs = err_cnt;
    @(negedge clk);
    expect_equal(irq, '0, "irq_o after reset");
    expect_equal(gpio_out, '0, "gpio_out_o after reset");
    expect_equal(gpio_dir, '0, "gpio_dir_o after reset");
    expect_equal(boot_addr, 32'h0000_8000, "boot_addr_o after reset");
    expect_equal(pad_mux, '0, "pad_mux_o after reset");
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_BOOT_ADDR), rd);
    expect_equal(rd, 32'h0000_8000, "BOOT_ADDR read");
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_CLK_GATE), rd);
    expect_equal(rd, 32'h0000_000F, "CLK_GATE read");      // All slots on
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_INFO), rd);
    expect_equal(rd, 32'd4, "INFO read");                   // Slot count
    report_test("reset values", errs);
  endtask

  task automatic test_soc_ctrl();
    periph_pkg::apb_data_t bval;
    periph_pkg::apb_data_t pval;
    periph_pkg::apb_data_t rd;
    int                    errs;
    errs = err_cnt;
    bval = $random(seed);
    pval = $random(seed);
    apb_write(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_BOOT_ADDR), bval);
    apb_write(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_PAD_MUX), pval);
    boot_exp = bval;
    pad_exp  = pval;
    @(negedge clk);
    expect_equal(boot_addr, bval, "boot_addr_o");
    expect_equal(pad_mux, pval, "pad_mux_o");
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_BOOT_ADDR), rd);
    expect_equal(rd, bval, "BOOT_ADDR read back");
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_PAD_MUX), rd);
    expect_equal(rd, pval, "PAD_MUX read back");
    report_test("soc control", errs);
  endtask

  task automatic test_gpio();
    periph_pkg::apb_data_t dval;
    periph_pkg::apb_data_t oval;
    periph_pkg::apb_data_t ival;
    periph_pkg::apb_data_t rd;
    int                    errs;
    errs = err_cnt;
    dval = $random(seed);
    oval = $random(seed);
    ival = $random(seed);
    apb_write(reg_addr(`PERIPH_SLOT_GPIO, `PERIPH_GPIO_DIR), dval);
    apb_write(reg_addr(`PERIPH_SLOT_GPIO, `PERIPH_GPIO_OUT), oval);
    dir_exp = dval;
    @(negedge clk);
    expect_equal(gpio_dir, dval, "gpio_dir_o");
    expect_equal(gpio_out, oval, "gpio_out_o");
    @(posedge clk);
    gpio_in <= ival;
    repeat (3) @(posedge clk);                               // Through the synchronizer
    apb_read(reg_addr(`PERIPH_SLOT_GPIO, `PERIPH_GPIO_IN), rd);
    expect_equal(rd, ival, "GPIO IN read");
    // Clean pending vector and then arm the GPIO interrupt
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_PENDING), 32'hFFFF_FFFF);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_IRQ_EN), 32'd1 << 25);
    apb_write(reg_addr(`PERIPH_SLOT_GPIO, `PERIPH_GPIO_INT_EN), 32'hFFFF_FFFF);
    @(posedge clk);
    gpio_in <= ~ival;                                        // Every bit toggles
    wait_irq_bit(25, 5);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_PENDING), 32'd1 << 25);
    @(negedge clk);
    expect_equal(irq, '0, "irq_o after PENDING clear");
    report_test("gpio", errs);
  endtask

  task automatic test_timer_events();
    periph_pkg::apb_data_t en_val;
    periph_pkg::apb_data_t set_val;
    periph_pkg::apb_data_t rd;
    int                    errs;
    errs = err_cnt;
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_PENDING), 32'hFFFF_FFFF);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_IRQ_EN), 32'd1 << 28);
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CMP), 32'd20);
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CTRL), 32'd1);
    wait_irq_bit(28, 30);
    // Stop the timer so no compare event lands during the SET check
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CTRL), 32'd0);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_PENDING), 32'hFFFF_FFFF);
    en_val  = $random(seed);
    set_val = $random(seed);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_IRQ_EN), en_val);
    apb_write(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_SET), set_val);
    @(negedge clk);
    expect_equal(irq, set_val & en_val, "irq_o after SET");
    apb_read(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_PENDING), rd);
    expect_equal(rd, set_val, "PENDING read");
    apb_read(reg_addr(`PERIPH_SLOT_EVENT, `PERIPH_EVT_SET), rd);
    expect_equal(rd, '0, "SET read");                        // Write-only word
    report_test("timer and events", errs);
  endtask

  task automatic test_clock_gating();
    periph_pkg::apb_data_t c0;
    periph_pkg::apb_data_t c1;
    int                    errs;
    errs = err_cnt;
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CMP), 32'hFFFF_FFFF);  // No wrap
    apb_write(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_CLK_GATE), 32'hD);       // Timer off
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CTRL), 32'd1);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_COUNT), c0);
    repeat (10) @(posedge clk);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_COUNT), c1);
    expect_equal(c1, c0, "COUNT while gated off");
    apb_write(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_CLK_GATE), 32'hF);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_COUNT), c0);
    repeat (10) @(posedge clk);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_COUNT), c1);
    expect_true(c1 != c0, "COUNT moves with gate on");
    expect_equal(c1 - c0, 32'd13, "COUNT delta");            // 13 edges between samples
    apb_write(reg_addr(`PERIPH_SLOT_TIMER, `PERIPH_TIMER_CTRL), 32'd0);
    report_test("clock gating", errs);
  endtask

  task automatic test_unmapped();
    periph_pkg::apb_data_t wval;
    periph_pkg::apb_data_t rd;
    logic                  err;
    int                    slot;
    int                    errs;
    errs = err_cnt;
    for (slot = 4; slot < 16; slot++) begin
      wval = $random(seed);
      apb_transfer(1'b1, reg_addr(slot, slot % 4), wval, rd, err);
      expect_true(err, $sformatf("pslverr_o on write to slot %0d", slot));
      apb_transfer(1'b0, reg_addr(slot, slot % 4), '0, rd, err);
      expect_true(err, $sformatf("pslverr_o on read from slot %0d", slot));
      expect_equal(rd, '0, $sformatf("read data from slot %0d", slot));
    end
    // Mapped registers untouched
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_BOOT_ADDR), rd);
    expect_equal(rd, boot_exp, "BOOT_ADDR after unmapped writes");
    apb_read(reg_addr(`PERIPH_SLOT_SOC, `PERIPH_SOC_PAD_MUX), rd);
    expect_equal(rd, pad_exp, "PAD_MUX after unmapped writes");
    apb_read(reg_addr(`PERIPH_SLOT_GPIO, `PERIPH_GPIO_DIR), rd);
    expect_equal(rd, dir_exp, "GPIO DIR after unmapped writes");
    report_test("unmapped slots", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed     = 36;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    gpio_in  = '0;
    boot_exp = 32'h0000_8000;
    pad_exp  = '0;
    dir_exp  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    test_soc_ctrl();
    test_gpio();
    test_timer_events();
    test_clock_gating();
    test_unmapped();
    $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/periph_pkg.sv
design/periph_apb_decode.sv
design/periph_gpio.sv
design/periph_timer.sv
design/periph_event_unit.sv
design/periph_soc_ctrl.sv
design/periph_read_mux.sv
design/periph_subsystem.sv
dv/tb_periph_subsystem.sv

/* Bender.yml */
package:
  name: periph_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/periph_pkg.sv
      - design/periph_apb_decode.sv
      - design/periph_gpio.sv
      - design/periph_timer.sv
      - design/periph_event_unit.sv
      - design/periph_soc_ctrl.sv
      - design/periph_read_mux.sv
      - design/periph_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_periph_subsystem.sv
